//--- sources.f
rtl/ocyrus_pkg.sv
rtl/lock_fsm.sv
rtl/phase_counter.sv
rtl/lane_serializer.sv
rtl/ocyrus_tx.sv
testbench/tx_checker.sv
testbench/tb_ocyrus_tx.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ocyrus_tx testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_ocyrus_tx -f sources.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee sim.log \
	|| echo "build or simulation aborted"

grep -qx "Simulation completed successfully" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

//--- testbench/tb_ocyrus_tx.sv
`timescale 1ns/1ps

module tb_ocyrus_tx;
	import ocyrus_pkg::*;

	localparam int SETTLE_CYCLES   = 6;  // short settle keeps the run small
	localparam int N_STRETCHES     = 12; // lock stretches, each followed by a drop
	localparam int WATCHDOG_CYCLES = N_STRETCHES * 220 + 50;

	logic         clock;
	logic         rst_n;
	logic         pll_locked;
	word_pair_t   words;
	logic         word_strobe;
	serial_pair_t serial;
	logic         locked;

	int          error_count;  // from the checker
	int          strobe_count;
	int          run_cycles;
	logic [31:0] rng_state;    // xorshift state

	ocyrus_tx #(
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) uut (
		.clock       (clock),
		.rst_n       (rst_n),
		.pll_locked  (pll_locked),
		.words       (words),
		.word_strobe (word_strobe),
		.serial      (serial),
		.locked      (locked)
	);

	tx_checker #(
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) chk (
		.clock        (clock),
		.rst_n        (rst_n),
		.pll_locked   (pll_locked),
		.words        (words),
		.word_strobe  (word_strobe),
		.serial       (serial),
		.locked       (locked),
		.error_count  (error_count),
		.strobe_count (strobe_count),
		.run_cycles   (run_cycles)
	);

	// 20 ns bit clock
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// xorshift32 step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// uniform pick in lo .. hi
	task automatic draw_range(input int lo, input int hi, output int value);
		rng_state = xorshift32(rng_state);
		value = lo + int'(rng_state % (hi - lo + 1));
	endtask

	// hold pll_locked at one level for n cycles, fresh word pair every cycle
	task automatic drive_cycles(input logic level, input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clock);
			rng_state = xorshift32(rng_state);
			pll_locked <= level;
			words      <= rng_state[15:0];
		end
	endtask

	initial begin : stimulus
		int high_len;
		int low_len;

		rng_state  = 32'hc811_d74b;
		rst_n      = 1'b0;
		pll_locked = 1'b0;
		words      = '0;

		repeat (5) @(posedge clock); // reset for 5 cycles
		rst_n <= 1'b1;

		drive_cycles(1'b0, 10); // no pll lock yet, outputs must stay quiet
		for (int s = 0; s < N_STRETCHES; s++) begin
			draw_range(40, 200, high_len); // long lock, ends at a random phase
			draw_range(1, 8, low_len);     // short drop
			drive_cycles(1'b1, high_len);
			drive_cycles(1'b0, low_len);
		end
		drive_cycles(1'b0, 10);

		@(negedge clock); // checker counters settled
		$display("checks done: %0d errors, %0d word strobes, %0d locked cycles",
			error_count, strobe_count, run_cycles);
		if (strobe_count == 0) begin
			$display("no word strobe was ever seen, the transmitter never reached RUN");
		end
		if (error_count == 0 && strobe_count > 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// bound on the whole run, longest stretch plus drop stays under 220 cycles
	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, stimulus did not finish",
			WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- testbench/tx_checker.sv
`timescale 1ns/1ps

module tx_checker #(
	parameter int SETTLE_CYCLES = 16
) (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     pll_locked,
	input  ocyrus_pkg::word_pair_t   words,
	input  logic                     word_strobe,
	input  ocyrus_pkg::serial_pair_t serial,
	input  logic                     locked,
	output int                       error_count,
	output int                       strobe_count,
	output int                       run_cycles
);
	import ocyrus_pkg::*;

	lock_state_t m_state;       // model of the lock sequence
	int          m_settle;      // cycles already spent in ALIGN
	int          m_phase;       // bit phase while running
	word_t       m_shift1;      // lane 1 bits still to go out, MSB next
	word_t       m_shift2;      // lane 2 bits still to go out
	logic        prev_locked;   // locked as seen one edge earlier
	int          since_high;    // edges since pll_locked was first seen high in WAIT
	logic        latency_armed; // a lock-up is in progress and may be timed

	// compare one observed value, report it in hex on a mismatch
	task automatic check_value(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (actual !== expected) begin
			error_count++;
			$display("ERR %s: expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
		end
	endtask

	// inputs and outputs are read at the edge before any register updates,
	// so each compare sees the values of the cycle that just ended
	always @(posedge clock) begin : compare_and_step
		logic exp_locked;
		logic exp_strobe;
		logic exp_bit1;
		logic exp_bit2;

		exp_locked = (m_state == LOCK_RUN); // locked only in RUN
		exp_strobe = exp_locked && (m_phase == 0); // one strobe per word
		exp_bit1   = exp_locked && m_shift1[WORD_WIDTH-1];
		exp_bit2   = exp_locked && m_shift2[WORD_WIDTH-1];

		if (!rst_n) begin
			m_state       = LOCK_WAIT;
			m_settle      = 0;
			m_phase       = 0;
			m_shift1      = '0;
			m_shift2      = '0;
			prev_locked   = 1'b0;
			since_high    = 0;
			latency_armed = 1'b0;
			error_count   = 0;
			strobe_count  = 0;
			run_cycles    = 0;
		end else begin
			check_value("locked", 32'(exp_locked), 32'(locked));
			check_value("word_strobe", 32'(exp_strobe), 32'(word_strobe));
			check_value("serial.bit1", 32'(exp_bit1), 32'(serial.bit1));
			check_value("serial.bit2", 32'(exp_bit2), 32'(serial.bit2));

			since_high++; // this edge counts toward the lock-up time

			// rise of locked timed from the edge that saw the pll come up
			if (locked && !prev_locked) begin
				if (!latency_armed) begin
					error_count++;
					$display("locked rose at %0t without a lock-up from WAIT", $time);
				end else begin
					check_value("lock_latency", SETTLE_CYCLES + 1, since_high);
				end
				latency_armed = 1'b0;
			end

			if (word_strobe) begin
				strobe_count++; // words handed to the lanes
			end
			if (locked) begin
				run_cycles++;
			end
			prev_locked = locked;

			// lanes empty outside RUN, capture on the strobe, else shift
			if (!exp_locked) begin
				m_shift1 = '0;
				m_shift2 = '0;
			end else if (exp_strobe) begin
				m_shift1 = words.word1; // word of the strobe cycle
				m_shift2 = words.word2;
			end else begin
				m_shift1 = m_shift1 << 1;
				m_shift2 = m_shift2 << 1;
			end

			// phase restarts at 0 on every entry into RUN
			m_phase = exp_locked ? (m_phase + 1) % WORD_WIDTH : 0;

			// lock sequence, a low pll always wins
			if (!pll_locked) begin
				m_state       = LOCK_WAIT;
				m_settle      = 0;
				latency_armed = 1'b0;
			end else begin
				case (m_state)
					LOCK_WAIT: begin
						m_state       = LOCK_ALIGN;
						m_settle      = 0;
						since_high    = 0; // start timing the lock-up
						latency_armed = 1'b1;
					end
					LOCK_ALIGN: begin
						if (m_settle == SETTLE_CYCLES - 1) begin
							m_state = LOCK_RUN; // settle interval over
						end else begin
							m_settle++;
						end
					end
					default: begin
						m_state = LOCK_RUN; // RUN holds while the pll stays up
					end
				endcase
			end
		end
	end

endmodule

//--- rtl/ocyrus_tx.sv
`timescale 1ns/1ps

module ocyrus_tx #(
	parameter int SETTLE_CYCLES = 16
) (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     pll_locked,
	input  ocyrus_pkg::word_pair_t   words,
	output logic                     word_strobe,
	output ocyrus_pkg::serial_pair_t serial,
	output logic                     locked
);
	import ocyrus_pkg::*;

	lock_state_t state;       // shared lock state, fsm to counter and lanes
	logic        settle_done; // counter back to fsm, last ALIGN cycle
	logic        load;        // word load strobe to both lanes

	// lock sequencing
	lock_fsm fsm (
		.clock       (clock),
		.rst_n       (rst_n),
		.pll_locked  (pll_locked),
		.settle_done (settle_done),
		.state       (state),
		.locked      (locked)
	);

	// settle timer and bit phase, one counter for both
	phase_counter #(
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) phase (
		.clock       (clock),
		.rst_n       (rst_n),
		.state       (state),
		.settle_done (settle_done),
		.load        (load)
	);

	assign word_strobe = load; // source presents a new pair on this pulse

	// lane 1, upper word of the pair
	lane_serializer lane1 (
		.clock      (clock),
		.rst_n      (rst_n),
		.state      (state),
		.load       (load),
		.word       (words.word1),
		.serial_bit (serial.bit1)
	);

	// lane 2, lower word of the pair
	lane_serializer lane2 (
		.clock      (clock),
		.rst_n      (rst_n),
		.state      (state),
		.load       (load),
		.word       (words.word2),
		.serial_bit (serial.bit2)
	);

endmodule

//--- rtl/lane_serializer.sv
`timescale 1ns/1ps

module lane_serializer (
	input  logic                    clock,
	input  logic                    rst_n,
	input  ocyrus_pkg::lock_state_t state,
	input  logic                    load,
	input  ocyrus_pkg::word_t       word,
	output logic                    serial_bit
);
	import ocyrus_pkg::*;

	word_t shift_reg; // MSB is the bit on the wire
	logic  in_run;

	assign in_run = (state == LOCK_RUN);

	// MSB out, forced low as soon as the state leaves RUN
	assign serial_bit = in_run && shift_reg[WORD_WIDTH-1];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			shift_reg <= '0;
		end else if (!in_run) begin
			shift_reg <= '0; // partial word is dropped on lock loss
		end else if (load) begin
			shift_reg <= word; // capture on the strobe, bit 7 shows next cycle
		end else begin
			shift_reg <= {shift_reg[WORD_WIDTH-2:0], 1'b0}; // shift left, zero fill
		end
	end

	// a captured word starts on the wire with its MSB
	a_msb_first: assert property (@(posedge clock) disable iff (!rst_n)
		(load ##1 in_run) |-> serial_bit == $past(word[WORD_WIDTH-1]))
		else $error("serial bit after load is not word bit 7");

	// the LSB of a word goes out on the cycle of the next strobe
	a_lsb_last: assert property (@(posedge clock) disable iff (!rst_n)
		(load ##1 in_run [*WORD_WIDTH]) |-> serial_bit == $past(word[0], WORD_WIDTH))
		else $error("serial bit at end of word is not word bit 0");

endmodule

//--- rtl/phase_counter.sv
`timescale 1ns/1ps

module phase_counter #(
	parameter int SETTLE_CYCLES = 16
) (
	input  logic                    clock,
	input  logic                    rst_n,
	input  ocyrus_pkg::lock_state_t state,
	output logic                    settle_done,
	output logic                    load
);
	import ocyrus_pkg::*;

	localparam int SETTLE_BITS = $clog2(SETTLE_CYCLES); // enough for 0 .. SETTLE_CYCLES-1
	localparam int CNT_BITS    = (SETTLE_BITS > PHASE_BITS) ? SETTLE_BITS : PHASE_BITS;

	localparam logic [CNT_BITS-1:0] SETTLE_LAST = CNT_BITS'(SETTLE_CYCLES - 1);
	localparam logic [CNT_BITS-1:0] PHASE_LAST  = CNT_BITS'(WORD_WIDTH - 1);

	logic [CNT_BITS-1:0] count; // settle cycles in ALIGN, bit phase in RUN
	logic                in_align;
	logic                in_run;

	assign in_align = (state == LOCK_ALIGN);
	assign in_run   = (state == LOCK_RUN);

	// last ALIGN cycle, fsm moves to RUN on the next edge
	assign settle_done = in_align && (count == SETTLE_LAST);

	// word strobe on phase 0, so the first RUN cycle loads too
	assign load = in_run && (count == '0);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			unique case (state)
				LOCK_ALIGN: begin
					if (settle_done) begin
						count <= '0; // phase 0 lines up with the first RUN cycle
					end else begin
						count <= count + 1'b1;
					end
				end
				LOCK_RUN: begin
					if (count == PHASE_LAST) begin
						count <= '0; // wrap every WORD_WIDTH cycles
					end else begin
						count <= count + 1'b1;
					end
				end
				default: begin
					count <= '0; // idle while waiting on the pll
				end
			endcase
		end
	end

	// strobe only while running
	a_load_in_run: assert property (@(posedge clock) disable iff (!rst_n)
		load |-> in_run)
		else $error("word load strobe outside LOCK_RUN");

	// strobes in RUN are spaced by exactly one word
	a_load_spacing: assert property (@(posedge clock) disable iff (!rst_n)
		load ##1 in_run [*WORD_WIDTH-1] |=> (load || !in_run))
		else $error("word load strobe spacing broken");

	// a settle interval always ends in RUN unless lock drops
	a_settle_to_run: assert property (@(posedge clock) disable iff (!rst_n)
		settle_done |=> (in_run || state == LOCK_WAIT))
		else $error("settle_done did not lead to RUN");

endmodule

//--- rtl/lock_fsm.sv
`timescale 1ns/1ps

module lock_fsm (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    pll_locked,
	input  logic                    settle_done,
	output ocyrus_pkg::lock_state_t state,
	output logic                    locked
);
	import ocyrus_pkg::*;

	lock_state_t next_state; // decoded from the current state and the pll level

	// next state
	// a low pll_locked always wins and sends the machine back to WAIT
	always_comb begin
		next_state = state; // hold by default
		if (!pll_locked) begin
			next_state = LOCK_WAIT;
		end else begin
			unique case (state)
				LOCK_WAIT: begin
					next_state = LOCK_ALIGN; // first edge with lock seen
				end
				LOCK_ALIGN: begin
					if (settle_done) begin
						next_state = LOCK_RUN; // settle interval over
					end
				end
				LOCK_RUN: begin
					next_state = LOCK_RUN; // stay until lock drops
				end
				default: begin
					next_state = LOCK_WAIT; // unused encoding
				end
			endcase
		end
	end

	// state register
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= LOCK_WAIT;
		end else begin
			state <= next_state;
		end
	end

	// locked follows the state register edge for edge, no decode glitches
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			locked <= 1'b0;
		end else begin
			locked <= (next_state == LOCK_RUN);
		end
	end

	// lock loss must reach the output on the very next edge
	a_drop_unlocks: assert property (@(posedge clock) disable iff (!rst_n)
		!pll_locked |=> !locked)
		else $error("locked still high after pll lock loss");

	// RUN is only reached through ALIGN
	a_run_via_align: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(locked) |-> $past(state) == LOCK_ALIGN)
		else $error("locked rose without a settle interval");

endmodule

//--- rtl/ocyrus_pkg.sv
package ocyrus_pkg;

	// bits per serialized word, one word per lane per strobe
	localparam int WORD_WIDTH = 8;

	// phase count width, log2 of the word width
	localparam int PHASE_BITS = $clog2(WORD_WIDTH);

	// one parallel word as presented to a lane
	typedef logic [WORD_WIDTH-1:0] word_t;

	// parallel words of both lanes, sampled on the word strobe
	typedef struct packed {
		word_t word1; // lane 1 word, upper byte
		word_t word2; // lane 2 word, lower byte
	} word_pair_t;

	// serial outputs of both lanes
	typedef struct packed {
		logic bit1; // lane 1 serial bit
		logic bit2; // lane 2 serial bit
	} serial_pair_t;

	// lock sequencing states
	// WAIT until the pll reports lock, ALIGN while it settles, RUN once serializing
	typedef enum logic [1:0] {
		LOCK_WAIT  = 2'd0, // pll not locked yet
		LOCK_ALIGN = 2'd1, // settle interval running
		LOCK_RUN   = 2'd2  // transmitter locked, words flowing
	} lock_state_t;

endpackage
